/* rtl/instr_bus_pkg.sv */
//////////////////////////////
// Instruction bus constants
// Address and data widths plus word alignment
//////////////////////////////

`default_nettype none

package instr_bus_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Byte step between two sequential word fetches
  localparam int unsigned WORD_BYTES = 4;

  // Clears the byte offset inside a word
  // Only word fetches are issued, no halfword alignment
  localparam logic [ADDR_W-1:0] WORD_ALIGN_MASK = ~(ADDR_W'(WORD_BYTES - 1));

endpackage

`default_nettype wire

/* rtl/prefetch_pkg.sv */
//////////////////////////////
// Prefetch buffer constants
// Counter width and reset fetch address
//////////////////////////////

`default_nettype none

package prefetch_pkg;

  //////////////////////////////
  // Occupancy counters
  //////////////////////////////

  // Width of the FIFO fill level and of the outstanding transfer count
  // Three bits hold the value DEPTH itself for depths up to 4
  localparam int unsigned FIFO_CNT_W = 3;

  //////////////////////////////
  // Fetch address
  //////////////////////////////

  // Address held until the fetch stage issues its first branch
  // The core boots with a branch to its start address
  localparam logic [31:0] RESET_FETCH_ADDR = 32'h0000_0000;

endpackage

`default_nettype wire

/* rtl/prefetch_controller.sv */
//////////////////////////////
// Prefetch controller
// Issues word fetches, bounds outstanding transfers
// and flushes responses of the old stream on a branch
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_controller #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // Fetch stage control
  input  logic                                req_i,
  input  logic                                branch_i,
  input  logic [instr_bus_pkg::ADDR_W-1:0]    branch_addr_i,
  output logic                                busy_o,
  // Transfer request towards the issue stage
  output logic                                trans_valid_o,
  input  logic                                trans_ready_i,
  output logic [instr_bus_pkg::ADDR_W-1:0]    trans_addr_o,
  // Bus response, always accepted
  input  logic                                resp_valid_i,
  // Fetch FIFO side
  output logic                                fifo_push_o,
  input  logic [prefetch_pkg::FIFO_CNT_W-1:0] fifo_cnt_i
);

  import instr_bus_pkg::*;
  import prefetch_pkg::*;

  // FSM encoding
  localparam logic ST_IDLE        = 1'b0;
  localparam logic ST_BRANCH_WAIT = 1'b1;

  // DEPTH at counter widths
  localparam logic [FIFO_CNT_W:0]   DEPTH_SUM = (FIFO_CNT_W + 1)'(DEPTH);
  localparam logic [FIFO_CNT_W-1:0] DEPTH_CNT = FIFO_CNT_W'(DEPTH);

  logic                  state_q;
  logic                  state_d;
  logic [FIFO_CNT_W-1:0] cnt_q;
  logic [FIFO_CNT_W-1:0] cnt_d;
  logic [FIFO_CNT_W-1:0] flush_cnt_q;
  logic [FIFO_CNT_W-1:0] flush_cnt_d;
  logic [FIFO_CNT_W:0]   occupancy;
  logic                  flush_active;
  logic                  trans_fire;
  logic [ADDR_W-1:0]     trans_addr_q;
  logic [ADDR_W-1:0]     trans_addr_incr;
  logic [ADDR_W-1:0]     aligned_branch_addr;

  //////////////////////////////
  // Request generation
  //////////////////////////////

  // Words in the FIFO plus words still on their way
  assign occupancy = {1'b0, fifo_cnt_i} + {1'b0, cnt_q};

  // No request unless every response is sure to find a FIFO slot
  assign trans_valid_o = req_i && (occupancy < DEPTH_SUM);
  assign trans_fire    = trans_valid_o && trans_ready_i;

  // Busy while anything is in flight or about to be issued
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  // Word fetches only
  assign aligned_branch_addr = branch_addr_i & WORD_ALIGN_MASK;
  assign trans_addr_incr     = trans_addr_q + ADDR_W'(WORD_BYTES);

  // Address select and branch replay
  always_comb begin
    state_d      = state_q;
    trans_addr_o = trans_addr_q;
    case (state_q)
      ST_IDLE: begin
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_incr;
        // Keep offering the target until the issue stage takes it
        if (branch_i && !trans_fire) begin
          state_d = ST_BRANCH_WAIT;
        end
      end
      ST_BRANCH_WAIT: begin
        // A newer branch replaces the waiting target
        trans_addr_o = branch_i ? aligned_branch_addr : trans_addr_q;
        if (trans_fire) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  //////////////////////////////
  // Outstanding and flush counts
  //////////////////////////////

  // Counts up on an accepted transfer and down on a response
  always_comb begin
    cnt_d = cnt_q;
    if (trans_fire && !resp_valid_i) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!trans_fire && resp_valid_i) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  assign flush_active = (flush_cnt_q != '0);

  // Every transfer outstanding at the branch belongs to the old stream
  // Words already in the FIFO are dropped there
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_d = cnt_q;
      // Response in the branch cycle is dropped right away
      if (resp_valid_i && (cnt_q != '0)) begin
        flush_cnt_d = cnt_q - 1'b1;
      end
    end else if (resp_valid_i && flush_active) begin
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  // Stale responses never reach the FIFO
  assign fifo_push_o = resp_valid_i && !(branch_i || flush_active);

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      cnt_q        <= '0;
      flush_cnt_q  <= '0;
      trans_addr_q <= RESET_FETCH_ADDR;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
      // Last issued or pending branch address
      if (branch_i || trans_fire) begin
        trans_addr_q <= trans_addr_o;
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= DEPTH_CNT)
    else $error("Outstanding transfer count above DEPTH");

  // Count stays at the limit unless a response frees a slot
  a_no_issue_at_limit: assert property (@(posedge clk) disable iff (!rst_n)
    ((cnt_q == DEPTH_CNT) && !resp_valid_i) |=> (cnt_q == DEPTH_CNT))
    else $error("Transfer accepted with DEPTH transfers outstanding");

  // Flushed responses are always a subset of the outstanding ones
  a_flush_bound: assert property (@(posedge clk) disable iff (!rst_n)
    flush_cnt_q <= cnt_q)
    else $error("Flush count above outstanding count");

endmodule

`default_nettype wire

/* rtl/bus_issue_stage.sv */
//////////////////////////////
// Bus issue stage
// One request register in front of the OBI instruction bus
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_issue_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  // Transfer request from the controller
  input  logic                             trans_valid_i,
  input  logic [instr_bus_pkg::ADDR_W-1:0] trans_addr_i,
  output logic                             trans_ready_o,
  // OBI address phase
  output logic                             instr_req_o,
  output logic [instr_bus_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic                             instr_gnt_i
);

  import instr_bus_pkg::*;

  logic              req_q;
  logic [ADDR_W-1:0] addr_q;
  logic              grant;
  logic              accept;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Held request leaves the register this cycle
  assign grant = req_q && instr_gnt_i;

  // Free slot, or the slot frees up on grant
  assign trans_ready_o = !req_q || grant;
  assign accept        = trans_valid_i && trans_ready_o;

  //////////////////////////////
  // Request register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= 1'b1;
    end else if (grant) begin
      req_q <= 1'b0;
    end
  end

  // Address only loads on accept, so it stays put until grant
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= trans_addr_i;
    end
  end

  // Bus driven straight from the register, no path from gnt to req
  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> instr_req_o)
    else $error("Request dropped before grant");

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> $stable(instr_addr_o))
    else $error("Bus address changed before grant");

endmodule

`default_nettype wire

/* rtl/fetch_fifo.sv */
//////////////////////////////
// Fetch FIFO
// Buffers returned instruction words and
// tracks the address of the word at its output
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // Write side, from the bus response
  input  logic                                push_i,
  input  logic [instr_bus_pkg::DATA_W-1:0]    push_data_i,
  // Read side, towards the fetch stage
  input  logic                                pop_i,
  output logic                                valid_o,
  output logic [instr_bus_pkg::DATA_W-1:0]    rdata_o,
  output logic [instr_bus_pkg::ADDR_W-1:0]    addr_o,
  // Branch flush
  input  logic                                flush_i,
  input  logic [instr_bus_pkg::ADDR_W-1:0]    flush_addr_i,
  output logic [prefetch_pkg::FIFO_CNT_W-1:0] cnt_o
);

  import instr_bus_pkg::*;
  import prefetch_pkg::*;

  localparam int unsigned           PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0]      LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [FIFO_CNT_W-1:0] FULL_CNT = FIFO_CNT_W'(DEPTH);

  logic [DATA_W-1:0]     mem_q [DEPTH];
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [FIFO_CNT_W-1:0] cnt_q;
  logic [ADDR_W-1:0]     addr_q;
  logic                  do_pop;

  // Pointer step with wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign valid_o = (cnt_q != '0);
  assign do_pop  = pop_i && valid_o;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Controller masks pushes during a flush
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  //////////////////////////////
  // Pointers, count, address
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
      addr_q   <= RESET_FETCH_ADDR;
    end else if (flush_i) begin
      // Branch drops all words and restarts at the target
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
      addr_q   <= flush_addr_i & WORD_ALIGN_MASK;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
        addr_q   <= addr_q + ADDR_W'(WORD_BYTES);
      end
      if (push_i && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && do_pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign rdata_o = mem_q[rd_ptr_q];
  assign addr_o  = addr_q;
  assign cnt_o   = cnt_q;

  // Controller's occupancy limit keeps a full FIFO from being written
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == FULL_CNT) |-> !push_i)
    else $error("Push into full fetch FIFO");

endmodule

`default_nettype wire

/* rtl/prefetch_buffer.sv */
//////////////////////////////
// Prefetch buffer top
// Controller, bus issue stage and fetch FIFO
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  // Fetch stage
  input  logic                             fetch_req_i,
  input  logic                             branch_i,
  input  logic [instr_bus_pkg::ADDR_W-1:0] branch_addr_i,
  input  logic                             fetch_ready_i,
  output logic                             fetch_valid_o,
  output logic [instr_bus_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic [instr_bus_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                             busy_o,
  // OBI instruction bus
  output logic                             instr_req_o,
  output logic [instr_bus_pkg::ADDR_W-1:0] instr_addr_o,
  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  input  logic [instr_bus_pkg::DATA_W-1:0] instr_rdata_i
);

  import instr_bus_pkg::*;
  import prefetch_pkg::*;

  // Controller to issue stage
  logic              trans_valid;
  logic              trans_ready;
  logic [ADDR_W-1:0] trans_addr;

  // Controller and FIFO
  logic                  fifo_push;
  logic                  fifo_pop;
  logic [FIFO_CNT_W-1:0] fifo_cnt;

  // Fetch stage takes a word
  assign fifo_pop = fetch_valid_o && fetch_ready_i;

  prefetch_controller #(
    .DEPTH (DEPTH)
  ) ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (fetch_req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .resp_valid_i  (instr_rvalid_i),
    .fifo_push_o   (fifo_push),
    .fifo_cnt_i    (fifo_cnt)
  );

  bus_issue_stage issue_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_addr_i  (trans_addr),
    .trans_ready_o (trans_ready),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i)
  );

  // Branch flushes the FIFO directly
  fetch_fifo #(
    .DEPTH (DEPTH)
  ) fifo_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (fifo_push),
    .push_data_i  (instr_rdata_i),
    .pop_i        (fifo_pop),
    .valid_o      (fetch_valid_o),
    .rdata_o      (fetch_rdata_o),
    .addr_o       (fetch_addr_o),
    .flush_i      (branch_i),
    .flush_addr_i (branch_addr_i),
    .cnt_o        (fifo_cnt)
  );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
//////////////////////////////
// Testbench clock and reset
// 20 ns clock, reset low for 2 cycles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned HALF_PERIOD_NS = 10,
  parameter int unsigned RESET_CYCLES   = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD_NS) clk = ~clk;
    end
  end

  // Released on a falling edge, half a cycle before the DUT samples
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/instr_mem_model.sv */
//////////////////////////////
// Instruction memory model
// OBI slave with random grant and in-order responses
// Responses come 1 to 4 cycles after grant
// Word at A is A ^ 32'hA5A5_0000
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instr_mem_model #(
  parameter logic [31:0] SEED = 32'hc311ff03
) (
  input  logic                             clk,
  input  logic                             rst_n,
  // Grant probability in percent
  input  int unsigned                      gnt_pct_i,
  // OBI address phase
  input  logic                             instr_req_i,
  input  logic [instr_bus_pkg::ADDR_W-1:0] instr_addr_i,
  output logic                             instr_gnt_o,
  // OBI response phase
  output logic                             instr_rvalid_o,
  output logic [instr_bus_pkg::DATA_W-1:0] instr_rdata_o
);

  import instr_bus_pkg::*;

  localparam logic [DATA_W-1:0] DATA_KEY = 32'hA5A5_0000;

  int                seed;
  int unsigned       cycle;
  int unsigned       due;
  int unsigned       last_due;
  int unsigned       gnt_pct_q;
  logic [ADDR_W-1:0] addr_q [$];
  int unsigned       due_q [$];

  initial begin
    seed           = SEED;
    cycle          = 0;
    last_due       = 0;
    gnt_pct_q      = 0;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
  end

  //////////////////////////////
  // Address phase
  //////////////////////////////

  // Granted addresses queue up with their due cycle
  always @(posedge clk) begin
    cycle++;
    // Grant percent in force for the coming cycle
    gnt_pct_q = gnt_pct_i;
    if (!rst_n) begin
      addr_q.delete();
      due_q.delete();
    end else if (instr_req_i && instr_gnt_o) begin
      due = cycle + 1 + ($unsigned($random(seed)) % 4);
      // Never overtake an older response
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      addr_q.push_back(instr_addr_i);
      due_q.push_back(due);
    end
  end

  //////////////////////////////
  // Grant and response
  //////////////////////////////

  // Driven on the falling edge and idle until the first rising edge
  always @(negedge clk) begin
    if (cycle != 0) begin
      instr_gnt_o = ($unsigned($random(seed)) % 100) < gnt_pct_q;
      // Head of the queue is due at the next rising edge
      if (due_q.size() != 0 && due_q[0] <= cycle + 1) begin
        instr_rvalid_o = 1'b1;
        instr_rdata_o  = addr_q[0] ^ DATA_KEY;
        void'(due_q.pop_front());
        void'(addr_q.pop_front());
      end else begin
        instr_rvalid_o = 1'b0;
        instr_rdata_o  = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/prefetch_buffer_tb.sv */
//////////////////////////////
// Prefetch buffer testbench
// Table of branch streams under random back-pressure and grant
// Scoreboard on address and data of every consumed word
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer_tb;

  import instr_bus_pkg::*;

  localparam int unsigned       DEPTH    = 4;
  localparam logic [31:0]       SEED     = 32'hc311ff03;
  localparam logic [DATA_W-1:0] DATA_KEY = 32'hA5A5_0000;
  localparam int                ROWS     = 6;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  // Branch target, words consumed, ready percent, grant percent,
  // branch while the previous stream still runs
  localparam logic [ADDR_W-1:0] ROW_TARGET [ROWS] = '{
    32'h0000_1000, 32'h0000_2002, 32'h0000_3001,
    32'h0000_4ffe, 32'h0000_5003, 32'h0000_6100
  };
  localparam int          ROW_WORDS [ROWS] = '{12, 10, 16, 8, 14, 10};
  localparam int unsigned ROW_READY [ROWS] = '{100, 70, 20, 90, 30, 100};
  localparam int unsigned ROW_GNT   [ROWS] = '{100, 60, 90, 30, 50, 80};
  localparam bit          ROW_MID   [ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};

  logic              clk;
  logic              rst_n;
  logic              fetch_req;
  logic              branch;
  logic [ADDR_W-1:0] branch_addr;
  logic              fetch_ready;
  logic              fetch_valid;
  logic [DATA_W-1:0] fetch_rdata;
  logic [ADDR_W-1:0] fetch_addr;
  logic              busy;
  logic              instr_req;
  logic [ADDR_W-1:0] instr_addr;
  logic              instr_gnt;
  logic              instr_rvalid;
  logic [DATA_W-1:0] instr_rdata;
  int unsigned       gnt_pct;

  int                seed;
  int                err_cnt;
  int                check_cnt;
  int                cycle_cnt;
  int                timeout_limit;
  int                grants;
  int                consumed;
  int                pending;
  logic [ADDR_W-1:0] exp_addr;
  logic [ADDR_W-1:0] hold_addr;
  logic              hold_q;
  logic              seen_rvalid;

  tb_clock_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  prefetch_buffer #(
    .DEPTH (DEPTH)
  ) dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_req_i    (fetch_req),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata)
  );

  instr_mem_model #(
    .SEED (SEED)
  ) mem_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .gnt_pct_i      (gnt_pct),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata)
  );

  task automatic check_that(input bit ok, input string what);
    check_cnt++;
    assert (ok) else begin
      $display("ERR %0t: %s", $time, what);
      err_cnt++;
    end
  endtask

  // True with the given percent probability
  function automatic bit roll(input int unsigned pct);
    roll = ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic int total_words();
    int sum;
    sum = 0;
    for (int r = 0; r < ROWS; r++) begin
      sum += ROW_WORDS[r];
    end
    return sum;
  endfunction

  // Drop the fetch request and wait for every response to return
  task automatic drain_to_idle();
    fetch_req   = 1'b0;
    fetch_ready = 1'b0;
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    check_that(!instr_req, "instr_req_o high with busy_o low");
    @(negedge clk);
    check_that(!instr_req && !busy, "instr_req_o or busy_o back high while idle");
  endtask

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout after %0d cycles, the fetch stream stalled", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////
  // Monitor and scoreboard
  //////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      hold_q      = 1'b0;
      seen_rvalid = 1'b0;
      pending     = 0;
    end else begin
      // Granted words still on the bus keep busy_o high
      check_that(pending == 0 || busy,
        $sformatf("busy_o low with %0d responses pending", pending));
      if (instr_req && instr_gnt) begin
        pending++;
      end
      if (instr_rvalid) begin
        pending--;
      end
      // OBI request and address held until grant
      if (hold_q) begin
        check_that(instr_req && instr_addr == hold_addr,
          $sformatf("instr_addr_o %h req %0b, held %h before grant",
            instr_addr, instr_req, hold_addr));
      end
      hold_q    = instr_req && !instr_gnt;
      hold_addr = instr_addr;
      if (instr_req) begin
        check_that(instr_addr[1:0] == 2'b00, $sformatf("unaligned instr_addr_o %h", instr_addr));
      end
      // Nothing to fetch before the first response
      if (!seen_rvalid) begin
        check_that(!fetch_valid, "fetch_valid_o high before any bus response");
      end
      if (instr_rvalid) begin
        seen_rvalid = 1'b1;
      end
      if (branch) begin
        // New stream starts at the word holding the target
        exp_addr = branch_addr & ~32'h3;
        grants   = 0;
        consumed = 0;
      end else begin
        if (instr_req && instr_gnt) begin
          grants++;
        end
        if (fetch_valid && fetch_ready) begin
          check_that(fetch_addr == exp_addr,
            $sformatf("fetch_addr_o %h, expected %h", fetch_addr, exp_addr));
          // Old-stream word shows up as a data mismatch
          check_that(fetch_rdata == (exp_addr ^ DATA_KEY),
            $sformatf("fetch_rdata_o %h, expected %h", fetch_rdata, exp_addr ^ DATA_KEY));
          exp_addr = exp_addr + 32'd4;
          consumed++;
        end
        // FIFO slots plus the one held request
        check_that(grants - consumed <= int'(DEPTH) + 1,
          $sformatf("%0d grants ahead of consumed words", grants - consumed));
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin : main
    int errs_before;
    seed          = SEED;
    err_cnt       = 0;
    check_cnt     = 0;
    cycle_cnt     = 0;
    grants        = 0;
    consumed      = 0;
    exp_addr      = '0;
    fetch_req     = 1'b0;
    branch        = 1'b0;
    branch_addr   = '0;
    fetch_ready   = 1'b0;
    gnt_pct       = 0;
    timeout_limit = total_words() * 20 + 200;
    @(posedge rst_n);
    @(negedge clk);
    check_that(!instr_req && !busy && !fetch_valid, "outputs not idle after reset");
    for (int r = 0; r < ROWS; r++) begin
      errs_before = err_cnt;
      gnt_pct     = ROW_GNT[r];
      if (!ROW_MID[r]) begin
        drain_to_idle();
      end
      // No word is taken in the branch cycle
      fetch_req   = 1'b1;
      branch      = 1'b1;
      branch_addr = ROW_TARGET[r];
      fetch_ready = 1'b0;
      @(negedge clk);
      branch      = 1'b0;
      branch_addr = $random(seed);
      while (consumed < ROW_WORDS[r]) begin
        fetch_ready = roll(ROW_READY[r]);
        @(negedge clk);
      end
      fetch_ready = 1'b0;
      $display("Row %0d: target %h, %0d words, ready %0d%%, grant %0d%%, mid %0b, %0d errors",
        r, ROW_TARGET[r], ROW_WORDS[r], ROW_READY[r], ROW_GNT[r], ROW_MID[r],
        err_cnt - errs_before);
    end
    drain_to_idle();
    $display("Summary: %0d rows, %0d checks, %0d errors", ROWS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/instr_bus_pkg.sv
rtl/prefetch_pkg.sv
rtl/prefetch_controller.sv
rtl/bus_issue_stage.sv
rtl/fetch_fifo.sv
rtl/prefetch_buffer.sv
tests/tb_clock_gen.sv
tests/instr_mem_model.sv
tests/prefetch_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the prefetch buffer testbench with Verilator
# Exit status is nonzero unless sim.log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -j 0 \
  --top-module prefetch_buffer_tb \
  -f project.f \
  -o prefetch_buffer_sim \
  > build.log 2>&1 \
  && ./obj_dir/prefetch_buffer_sim > sim.log 2>&1 \
  && grep -qx "Testbench passed" sim.log \
  && echo "Simulation OK" \
  || { echo "Simulation FAILED, see build.log and sim.log"; exit 1; }

exit 0
